// ==== verilog/alu_ctl_pkg.sv ====
package alu_ctl_pkg;

  localparam int data_width = 8;

  // status byte layout, as on the 6502.
  localparam int flag_c_pos = 0;
  localparam int flag_z_pos = 1;
  localparam int flag_v_pos = 6;
  localparam int flag_n_pos = 7;

  // one-hot alu control, all zero passes lhs.
  typedef struct packed {
    logic adc;
    logic sbc;
    logic cmp;
    logic inc;
    logic dec;
    logic bit_test;
    logic and_op;
    logic ora;
    logic eor;
    logic rol;
    logic asl;
    logic ror;
    logic lsr;
    logic txl;
    logic txr;
  } alu_ctl_t;

  typedef enum logic [3:0] {
    op_adc = 4'd0,
    op_sbc = 4'd1,
    op_cmp = 4'd2,
    op_inc = 4'd3,
    op_dec = 4'd4,
    op_bit = 4'd5,
    op_and = 4'd6,
    op_ora = 4'd7,
    op_eor = 4'd8,
    op_rol = 4'd9,
    op_asl = 4'd10,
    op_ror = 4'd11,
    op_lsr = 4'd12,
    op_txl = 4'd13,
    op_txr = 4'd14,
    op_nop = 4'd15
  } alu_op_e;

  typedef struct packed {
    logic sign;
    logic overflow;
    logic zero;
    logic carry;
  } alu_flags_t;

  // set bit lets the alu change that flag.
  typedef struct packed {
    logic sign;
    logic overflow;
    logic zero;
    logic carry;
  } flag_mask_t;

endpackage

// ==== verilog/alu_bus_pkg.sv ====
package alu_bus_pkg;

  import alu_ctl_pkg::*;

  // wishbone classic, master to slave.
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [2:0]            adr;
    logic [data_width-1:0] dat;
  } wb_req_t;

  // slave to master.
  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] dat;
  } wb_rsp_t;

  // 5 to 7 unused.
  typedef enum logic [2:0] {
    reg_lhs    = 3'd0,
    reg_rhs    = 3'd1,
    reg_status = 3'd2,
    reg_cmd    = 3'd3,
    reg_result = 3'd4
  } reg_addr_e;

endpackage

// ==== verilog/core_alu.sv ====
`timescale 1ns/1ps

module core_alu
  import alu_ctl_pkg::*;
(
  input  alu_ctl_t              control,
  input  flag_mask_t            flag_mask,
  input  logic [data_width-1:0] lhs,
  input  logic [data_width-1:0] rhs,
  input  alu_flags_t            flags_in,
  output logic [data_width-1:0] result,
  output alu_flags_t            flags_out
);

  logic [data_width:0] add_rhs;
  logic [data_width:0] sum;
  logic                add_ovf;
  alu_flags_t          raw;

  // adder shared by adc and sbc.
  always_comb
  begin
    add_rhs = control.sbc ? {1'b0, ~rhs} : {1'b0, rhs};
    sum     = {1'b0, lhs} + add_rhs + {{data_width{1'b0}}, flags_in.carry};
    add_ovf = (lhs[data_width-1] == add_rhs[data_width-1]) &&
              (lhs[data_width-1] != sum[data_width-1]);
  end

  always_comb
  begin
    result = lhs;
    raw    = flags_in;

    case (1'b1)
      control.adc, control.sbc:
      begin
        result       = sum[data_width-1:0];
        raw.carry    = sum[data_width] ^ control.sbc; // sbc reports inverted carry.
        raw.overflow = add_ovf;
      end
      control.cmp:                      result = lhs - rhs;
      control.inc:                      result = lhs + 1'b1;
      control.dec:                      result = lhs - 1'b1;
      control.bit_test, control.and_op: result = lhs & rhs;
      control.ora:                      result = lhs | rhs;
      control.eor:                      result = lhs ^ rhs;
      control.rol:                      {raw.carry, result} = {lhs, flags_in.carry};
      control.asl:                      {raw.carry, result} = {lhs, 1'b0};
      control.ror:                      {result, raw.carry} = {flags_in.carry, lhs};
      control.lsr:                      {result, raw.carry} = {1'b0, lhs};
      control.txl:                      result = lhs;
      control.txr:                      result = rhs;
      default:                          result = lhs;
    endcase

    if (|control)
    begin
      raw.zero = (result == '0);
      raw.sign = result[data_width-1];
    end

    // cmp sets carry when lhs >= rhs.
    if (control.cmp)
      raw.carry = raw.zero || (lhs > rhs);

    if (control.bit_test)
    begin
      raw.sign     = rhs[data_width-1];
      raw.overflow = rhs[data_width-2];
    end

    // masked flags pass through.
    flags_out.carry    = flag_mask.carry    ? raw.carry    : flags_in.carry;
    flags_out.zero     = flag_mask.zero     ? raw.zero     : flags_in.zero;
    flags_out.overflow = flag_mask.overflow ? raw.overflow : flags_in.overflow;
    flags_out.sign     = flag_mask.sign     ? raw.sign     : flags_in.sign;
  end

endmodule

// ==== verilog/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder
  import alu_ctl_pkg::*;
(
  input  alu_op_e    op,
  output alu_ctl_t   control,
  output flag_mask_t flag_mask
);

  // one control bit per opcode.
  always_comb
  begin
    control = '0;
    case (op)
      op_adc:  control.adc      = 1'b1;
      op_sbc:  control.sbc      = 1'b1;
      op_cmp:  control.cmp      = 1'b1;
      op_inc:  control.inc      = 1'b1;
      op_dec:  control.dec      = 1'b1;
      op_bit:  control.bit_test = 1'b1;
      op_and:  control.and_op   = 1'b1;
      op_ora:  control.ora      = 1'b1;
      op_eor:  control.eor      = 1'b1;
      op_rol:  control.rol      = 1'b1;
      op_asl:  control.asl      = 1'b1;
      op_ror:  control.ror      = 1'b1;
      op_lsr:  control.lsr      = 1'b1;
      op_txl:  control.txl      = 1'b1;
      op_txr:  control.txr      = 1'b1;
      default: control          = '0; // nop.
    endcase
  end

  // flags each opcode may touch.
  always_comb
  begin
    flag_mask = '0;
    case (op)
      op_adc, op_sbc:
      begin
        flag_mask = '{sign: 1'b1, overflow: 1'b1, zero: 1'b1, carry: 1'b1};
      end
      op_and, op_ora, op_eor, op_inc, op_dec, op_txl, op_txr:
      begin
        flag_mask = '{sign: 1'b1, overflow: 1'b0, zero: 1'b1, carry: 1'b0};
      end
      op_cmp, op_rol, op_asl, op_ror, op_lsr:
      begin
        flag_mask = '{sign: 1'b1, overflow: 1'b0, zero: 1'b1, carry: 1'b1};
      end
      op_bit:
      begin
        // n and v come from rhs.
        flag_mask = '{sign: 1'b1, overflow: 1'b1, zero: 1'b1, carry: 1'b0};
      end
      default:
      begin
        flag_mask = '0;
      end
    endcase
  end

endmodule

// ==== verilog/alu_wb_regs.sv ====
`timescale 1ns/1ps

module alu_wb_regs
  import alu_ctl_pkg::*, alu_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  wb_req_t               wb_req,
  output wb_rsp_t               wb_rsp,
  output alu_op_e               op,
  output logic [data_width-1:0] lhs,
  output logic [data_width-1:0] rhs,
  output alu_flags_t            flags,
  input  logic [data_width-1:0] alu_result,
  input  alu_flags_t            alu_flags
);

  logic                  ack;
  logic                  access;
  logic                  wr_en;
  logic                  cmd_wr;
  logic [3:0]            cmd_reg;
  logic [data_width-1:0] result_reg;
  logic [data_width-1:0] status_byte;
  logic [data_width-1:0] rd_mux;
  logic [data_width-1:0] rd_dat;

  // new transfer sampled this cycle.
  assign access = wb_req.cyc & wb_req.stb & ~ack;
  assign wr_en  = access & wb_req.we;
  assign cmd_wr = wr_en && (wb_req.adr == reg_cmd);

  // opcode goes straight from the bus to the decoder.
  assign op = cmd_wr ? alu_op_e'(wb_req.dat[3:0]) : op_nop;

  always_comb
  begin
    status_byte             = '0;
    status_byte[flag_c_pos] = flags.carry;
    status_byte[flag_z_pos] = flags.zero;
    status_byte[flag_v_pos] = flags.overflow;
    status_byte[flag_n_pos] = flags.sign;
  end

  always_comb
  begin
    case (wb_req.adr)
      reg_lhs:    rd_mux = lhs;
      reg_rhs:    rd_mux = rhs;
      reg_status: rd_mux = status_byte;
      reg_cmd:    rd_mux = {{(data_width-4){1'b0}}, cmd_reg};
      reg_result: rd_mux = result_reg;
      default:    rd_mux = '0;
    endcase
  end

  // single cycle ack.
  always_ff @(posedge clk)
  begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= access;
  end

  always_ff @(posedge clk)
  begin
    if (access)
      rd_dat <= rd_mux; // valid while ack is high.
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lhs        <= '0;
      rhs        <= '0;
      flags      <= '0;
      cmd_reg    <= '0;
      result_reg <= '0;
    end
    else if (wr_en)
    begin
      case (wb_req.adr)
        reg_lhs: lhs <= wb_req.dat;
        reg_rhs: rhs <= wb_req.dat;
        reg_status:
        begin
          flags.carry    <= wb_req.dat[flag_c_pos];
          flags.zero     <= wb_req.dat[flag_z_pos];
          flags.overflow <= wb_req.dat[flag_v_pos];
          flags.sign     <= wb_req.dat[flag_n_pos];
        end
        reg_cmd:
        begin
          cmd_reg    <= wb_req.dat[3:0];
          result_reg <= alu_result; // commit on the acking edge.
          flags      <= alu_flags;
        end
        default: ;
      endcase
    end
  end

  assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

// ==== verilog/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
  import alu_ctl_pkg::*, alu_bus_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  alu_op_e               op;
  alu_ctl_t              control;
  flag_mask_t            flag_mask;
  logic [data_width-1:0] lhs;
  logic [data_width-1:0] rhs;
  alu_flags_t            flags;
  logic [data_width-1:0] alu_result;
  alu_flags_t            alu_flags;

  alu_wb_regs alu_wb_regs_inst (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .op         (op),
    .lhs        (lhs),
    .rhs        (rhs),
    .flags      (flags),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  op_decoder op_decoder_inst (
    .op        (op),
    .control   (control),
    .flag_mask (flag_mask)
  );

  core_alu core_alu_inst (
    .control   (control),
    .flag_mask (flag_mask),
    .lhs       (lhs),
    .rhs       (rhs),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

endmodule

// ==== test/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// 6502 status byte, bits 2 to 5 read zero.
function automatic logic [7:0] status_of(input logic n, input logic v,
                                         input logic z, input logic c);
  return {n, v, 4'b0000, z, c};
endfunction

// expected {status, result} for one command.
function automatic logic [15:0] model_step(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b, input logic [7:0] st);
  logic [8:0] wide;
  logic [7:0] bb;
  logic [7:0] res;
  logic [3:0] upd;
  logic       nn;
  logic       vn;
  logic       zn;
  logic       cn;

  res = a;
  bb  = b;
  upd = 4'b0000; // n, v, z, c.
  vn  = st[6];
  cn  = st[0];
  case (op)
    op_adc, op_sbc:
    begin
      if (op == op_sbc)
        bb = ~b;
      wide = {1'b0, a} + {1'b0, bb} + {8'h00, st[0]};
      res  = wide[7:0];
      cn   = wide[8] ^ (op == op_sbc); // borrow reads as inverted carry.
      vn   = (a[7] == bb[7]) && (a[7] != res[7]);
      upd  = 4'b1111;
    end
    op_cmp:
    begin
      res = a - b;
      cn  = (res == 8'h00) || (a > b);
      upd = 4'b1011;
    end
    op_inc: {upd, res} = {4'b1010, a + 8'd1};
    op_dec: {upd, res} = {4'b1010, a - 8'd1};
    op_bit: {upd, res} = {4'b1110, a & b};
    op_and: {upd, res} = {4'b1010, a & b};
    op_ora: {upd, res} = {4'b1010, a | b};
    op_eor: {upd, res} = {4'b1010, a ^ b};
    op_rol: {upd, cn, res} = {4'b1011, a, st[0]};
    op_asl: {upd, cn, res} = {4'b1011, a, 1'b0};
    op_ror: {upd, res, cn} = {4'b1011, st[0], a};
    op_lsr: {upd, res, cn} = {4'b1011, 1'b0, a};
    op_txl: {upd, res} = {4'b1010, a};
    op_txr: {upd, res} = {4'b1010, b};
    default: upd = 4'b0000; // nop passes lhs.
  endcase

  zn = (res == 8'h00);
  nn = res[7];
  if (op == op_bit)
  begin
    nn = b[7];
    vn = b[6];
  end

  return {status_of(upd[3] ? nn : st[7], upd[2] ? vn : st[6],
                    upd[1] ? zn : st[1], upd[0] ? cn : st[0]), res};
endfunction

`endif

// ==== test/alu_unit_tb.sv ====
`timescale 1ns/1ps

module alu_unit_tb
  import alu_ctl_pkg::*, alu_bus_pkg::*;
();

  localparam int reset_cycles = 10;
  localparam int txn_count    = 5 + 10 * 12 + 1200 * 6 + 11 + 3 + 23 * 3; // bus transfers.

  logic        clk;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] rand_state = 32'ha92d;
  logic [7:0]  cur_lhs;
  logic [7:0]  cur_rhs;
  logic [7:0]  cur_status; // model copy of the status register.
  logic        ack_seen;

  `include "alu_model.svh"

  alu_unit alu_unit_inst (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  function logic [7:0] rand_byte();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state[23:16];
  endfunction

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual === expected)
    else
      abort_run($sformatf("Fail at %0t ns: %s expected 0x%02h actual 0x%02h",
                          $time, name, expected, actual));
  endtask

  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdata);
    int waited;

    @(posedge clk);
    #1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    waited = 0;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 8)
        abort_run("no ack from the bus slave");
    end
    while (!wb_rsp.ack);
    rdata  = wb_rsp.dat; // still valid while ack is high.
    wb_req = '0;
    assert (waited == 1)
    else
      abort_run($sformatf("ack came %0d cycles after the request", waited));
  endtask

  task automatic bus_write(input logic [2:0] adr, input logic [7:0] dat);
    logic [7:0] unused;

    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic read_expect(input logic [2:0] adr, input logic [7:0] expected,
                             input string name);
    logic [7:0] got;

    bus_cycle(1'b0, adr, 8'h00, got);
    check_byte(name, expected, got);
  endtask

  task automatic load_operands(input logic [7:0] a, input logic [7:0] b, input logic [7:0] st);
    bus_write(reg_lhs, a);
    bus_write(reg_rhs, b);
    bus_write(reg_status, st);
    cur_lhs    = a;
    cur_rhs    = b;
    cur_status = st & 8'hc3;
  endtask

  // issue one command and check result and flags against the model.
  task automatic exec_cmd(input logic [3:0] op);
    logic [15:0] expected;

    expected = model_step(op, cur_lhs, cur_rhs, cur_status);
    bus_write(reg_cmd, {4'h0, op});
    read_expect(reg_result, expected[7:0], $sformatf("result (op %0d)", op));
    read_expect(reg_status, expected[15:8], $sformatf("status (op %0d)", op));
    cur_status = expected[15:8];
  endtask

  // ack must drop after a single cycle.
  always @(negedge clk)
  begin
    if (reset)
      ack_seen = 1'b0;
    else
    begin
      assert (!(wb_rsp.ack && ack_seen))
      else
        abort_run("ack stayed high for more than one cycle");
      ack_seen = wb_rsp.ack;
    end
  end

  initial
  begin
    repeat (reset_cycles + txn_count * 20) @(posedge clk);
    abort_run("watchdog timeout, the run did not finish");
  end

  initial
  begin
    reset  = 1'b1;
    wb_req = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (!wb_rsp.ack)
    else
      abort_run("ack is high right after reset");

    for (int adr = 0; adr < 5; adr++)
      read_expect(adr, 8'h00, $sformatf("reset value at address %0d", adr));

    for (int i = 0; i < 10; i++)
    begin
      load_operands(rand_byte(), rand_byte(), rand_byte());
      read_expect(reg_lhs, cur_lhs, "lhs");
      read_expect(reg_rhs, cur_rhs, "rhs");
      read_expect(reg_status, cur_status, "status");
      for (int adr = 5; adr < 8; adr++)
      begin
        bus_write(adr, rand_byte()); // should be ignored.
        read_expect(adr, 8'h00, $sformatf("unused address %0d", adr));
      end
    end

    for (int i = 0; i < 600; i++)
    begin
      load_operands(rand_byte(), rand_byte(), rand_byte());
      exec_cmd(rand_byte() % 5); // adc, sbc, cmp, inc, dec.
    end

    for (int i = 0; i < 600; i++)
    begin
      load_operands(rand_byte(), rand_byte(), rand_byte());
      exec_cmd(5 + rand_byte() % 10);
    end

    load_operands(8'h5a, 8'h33, 8'hc3);
    exec_cmd(op_nop);
    read_expect(reg_cmd, 8'h0f, "cmd");
    exec_cmd(op_eor);
    read_expect(reg_cmd, 8'h08, "cmd");

    // chained adds carry into each other.
    load_operands(8'hff, 8'h01, 8'h00);
    repeat (3) exec_cmd(op_adc);
    for (int i = 0; i < 20; i++)
      exec_cmd(rand_byte() % 16);

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== alu_unit.f ====
verilog/alu_ctl_pkg.sv
verilog/alu_bus_pkg.sv
verilog/core_alu.sv
verilog/op_decoder.sv
verilog/alu_wb_regs.sv
verilog/alu_unit.sv
+incdir+test
test/alu_unit_tb.sv
